// File: compile.f
source/mem_uart_pkg.sv
source/rx_queue.sv
source/io_status_regs.sv
source/mem_bus_ctrl.sv
source/mem_uart_top.sv
verif/mem_uart_checker.sv
verif/tb_mem_uart.sv

// File: run.sh
#!/bin/sh
# Build and run the mem_uart simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_mem_uart -o sim_mem_uart
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mem_uart > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
exit 0

// File: source/io_status_regs.sv
`timescale 1ns/1ns

module io_status_regs (
	input  logic                            clk,
	input  logic                            rst,
	input  mem_uart_pkg::uart_flags_t       flags,
	output mem_uart_pkg::uart_flags_t       flags_sync,
	input  logic                            empty,
	input  logic                            drop,
	input  logic                            status_rd,
	output logic [mem_uart_pkg::data_w-1:0] status_word
);

	mem_uart_pkg::uart_flags_t flags_meta;
	logic                      overflow;

	////////////////////////////////////////////////////////////
	// Two-flop synchronizer for the chip flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			flags_meta <= '0;
			flags_sync <= '0;
		end else begin
			flags_meta <= flags;
			flags_sync <= flags_meta;
		end
	end

	// Sticky overflow, a new drop wins over a clearing read
	always_ff @(posedge clk) begin
		if (!rst)
			overflow <= 1'b0;
		else if (drop)
			overflow <= 1'b1;
		else if (status_rd)
			overflow <= 1'b0;
	end

	// Status word, unused bits read zero
	always_comb begin
		status_word = '0;
		status_word[mem_uart_pkg::stat_tx_ready_bit] = flags_sync.tbre && flags_sync.tsre;
		status_word[mem_uart_pkg::stat_rx_avail_bit] = !empty;
		status_word[mem_uart_pkg::stat_overflow_bit] = overflow;
	end

endmodule

// File: source/mem_bus_ctrl.sv
`timescale 1ns/1ns

module mem_bus_ctrl (
	input  logic                                clk,
	input  logic                                rst,
	input  mem_uart_pkg::mem_req_t              req,
	output logic                                done,
	output logic [mem_uart_pkg::tag_w-1:0]      done_tag,
	output logic [mem_uart_pkg::data_w-1:0]     result,
	output mem_uart_pkg::sram_pins_t            sram,
	output mem_uart_pkg::uart_pins_t            uart,
	input  mem_uart_pkg::uart_flags_t           flags_sync,
	output logic [mem_uart_pkg::data_w-1:0]     bus_out,
	output logic                                bus_oe,
	input  logic [mem_uart_pkg::data_w-1:0]     bus_in,
	output logic                                push,
	output logic [mem_uart_pkg::data_w-1:0]     push_data,
	output logic                                pop,
	input  logic [mem_uart_pkg::data_w-1:0]     front_data,
	input  logic                                empty,
	input  logic                                full,
	output logic                                drop,
	output logic                                status_rd,
	input  logic [mem_uart_pkg::data_w-1:0]     status_word
);

	mem_uart_pkg::ctrl_state_e state;

	// Pin strobes, all active low
	logic en_n;
	logic oe_n;
	logic we_n;
	logic rdn;
	logic wrn;
	logic [mem_uart_pkg::addr_w-1:0] sram_addr;

	// Served tag tracking
	logic [mem_uart_pkg::tag_w-1:0] last_tag;
	logic                           tag_valid;

	logic io_status_sel;
	logic is_data_addr;
	logic is_status_addr;
	logic start_op;

	assign sram = '{en_n: en_n, oe_n: oe_n, we_n: we_n, addr: sram_addr};
	assign uart = '{rdn: rdn, wrn: wrn};
	assign done_tag = last_tag;

	////////////////////////////////////////////////////////////
	// Request decode
	////////////////////////////////////////////////////////////
	assign is_data_addr   = (req.addr == mem_uart_pkg::uart_data_addr);
	assign is_status_addr = (req.addr == mem_uart_pkg::uart_status_addr);

	// New tag only, and a pending receive always goes first
	assign start_op = !flags_sync.data_ready && req.valid && (req.rd || req.wr) &&
		(!tag_valid || req.tag != last_tag);

	// Data bus is driven for the whole write sequence
	always_comb begin
		bus_oe = state inside {mem_uart_pkg::RAM_WR1, mem_uart_pkg::RAM_WR2,
			mem_uart_pkg::RAM_WR3, mem_uart_pkg::UART_TX1, mem_uart_pkg::UART_TX2,
			mem_uart_pkg::UART_TX3, mem_uart_pkg::UART_TX4, mem_uart_pkg::UART_TX5};
	end

	////////////////////////////////////////////////////////////
	// State machine and strobes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			state     <= mem_uart_pkg::IDLE;
			en_n      <= 1'b1;
			oe_n      <= 1'b1;
			we_n      <= 1'b1;
			rdn       <= 1'b1;
			wrn       <= 1'b1;
			done      <= 1'b0;
			push      <= 1'b0;
			pop       <= 1'b0;
			drop      <= 1'b0;
			status_rd <= 1'b0;
			last_tag  <= '0;
			tag_valid <= 1'b0;
		end else begin
			// Single-cycle pulses
			push      <= 1'b0;
			pop       <= 1'b0;
			drop      <= 1'b0;
			status_rd <= 1'b0;

			case (state)
				mem_uart_pkg::IDLE: begin
					if (flags_sync.data_ready) begin
						state <= mem_uart_pkg::UART_RX1;
					end else if (start_op) begin
						done      <= 1'b0;
						last_tag  <= req.tag;
						tag_valid <= 1'b1;
						if (is_data_addr) begin
							state <= req.wr ? mem_uart_pkg::UART_TX1 : mem_uart_pkg::IO_RD1;
						end else if (is_status_addr) begin
							// Status word is read only, a write just completes
							state <= req.wr ? mem_uart_pkg::IO_RD2 : mem_uart_pkg::IO_RD1;
						end else begin
							state <= req.wr ? mem_uart_pkg::RAM_WR1 : mem_uart_pkg::RAM_RD1;
						end
					end
				end

				// Drain one byte from the UART chip
				mem_uart_pkg::UART_RX1: begin
					rdn   <= 1'b0;
					state <= mem_uart_pkg::UART_RX2;
				end
				mem_uart_pkg::UART_RX2: begin
					state <= mem_uart_pkg::UART_RX3;
				end
				mem_uart_pkg::UART_RX3: begin
					rdn <= 1'b1;
					if (full)
						drop <= 1'b1;
					else
						push <= 1'b1;
					state <= mem_uart_pkg::IDLE;
				end

				// Send one byte, then wait for the shifter to empty
				mem_uart_pkg::UART_TX1: begin
					wrn   <= 1'b1;
					state <= mem_uart_pkg::UART_TX2;
				end
				mem_uart_pkg::UART_TX2: begin
					wrn <= 1'b0;
					if (!flags_sync.tbre)
						state <= mem_uart_pkg::UART_TX3;
				end
				mem_uart_pkg::UART_TX3: begin
					wrn   <= 1'b1;
					state <= mem_uart_pkg::UART_TX4;
				end
				mem_uart_pkg::UART_TX4: begin
					if (flags_sync.tbre)
						state <= mem_uart_pkg::UART_TX5;
				end
				mem_uart_pkg::UART_TX5: begin
					if (flags_sync.tsre) begin
						done  <= 1'b1;
						state <= mem_uart_pkg::IDLE;
					end
				end

				mem_uart_pkg::RAM_RD1: begin
					en_n  <= 1'b0;
					state <= mem_uart_pkg::RAM_RD2;
				end
				mem_uart_pkg::RAM_RD2: begin
					oe_n  <= 1'b0;
					state <= mem_uart_pkg::RAM_RD3;
				end
				mem_uart_pkg::RAM_RD3: begin
					en_n  <= 1'b1;
					oe_n  <= 1'b1;
					done  <= 1'b1;
					state <= mem_uart_pkg::IDLE;
				end

				mem_uart_pkg::RAM_WR1: begin
					en_n  <= 1'b0;
					state <= mem_uart_pkg::RAM_WR2;
				end
				mem_uart_pkg::RAM_WR2: begin
					we_n  <= 1'b0;
					state <= mem_uart_pkg::RAM_WR3;
				end
				mem_uart_pkg::RAM_WR3: begin
					we_n  <= 1'b1;
					en_n  <= 1'b1;
					done  <= 1'b1;
					state <= mem_uart_pkg::IDLE;
				end

				mem_uart_pkg::IO_RD1: begin
					if (io_status_sel)
						status_rd <= 1'b1;
					else if (!empty)
						pop <= 1'b1;
					state <= mem_uart_pkg::IO_RD2;
				end
				mem_uart_pkg::IO_RD2: begin
					done  <= 1'b1;
					state <= mem_uart_pkg::IDLE;
				end

				default: state <= mem_uart_pkg::IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Data path registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		case (state)
			mem_uart_pkg::IDLE: begin
				if (!flags_sync.data_ready && start_op) begin
					sram_addr     <= req.addr;
					io_status_sel <= is_status_addr;
					// UART chip takes only the low byte
					if (is_data_addr)
						bus_out <= {8'h00, req.wdata[7:0]};
					else
						bus_out <= req.wdata;
				end
			end
			mem_uart_pkg::UART_RX2: push_data <= {8'h00, bus_in[7:0]};
			mem_uart_pkg::RAM_RD3:  result <= bus_in;
			mem_uart_pkg::IO_RD1: begin
				if (io_status_sel)
					result <= status_word;
				else if (empty)
					result <= '0;
				else
					result <= front_data;
			end
			default: ;
		endcase
	end

endmodule

// File: source/mem_uart_pkg.sv
package mem_uart_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int addr_w      = 16;
	localparam int data_w      = 16;
	localparam int tag_w       = 4;
	localparam int queue_depth = 16;
	localparam int ptr_w       = 4;

	////////////////////////////////////////////////////////////
	// Address map and status word layout
	////////////////////////////////////////////////////////////
	localparam logic [addr_w-1:0] uart_data_addr   = 16'hBF00;
	localparam logic [addr_w-1:0] uart_status_addr = 16'hBF01;

	localparam int stat_tx_ready_bit = 0;
	localparam int stat_rx_avail_bit = 1;
	localparam int stat_overflow_bit = 2;

	// Bus controller states
	typedef enum logic [4:0] {
		IDLE,
		UART_RX1, UART_RX2, UART_RX3,
		UART_TX1, UART_TX2, UART_TX3, UART_TX4, UART_TX5,
		RAM_RD1, RAM_RD2, RAM_RD3,
		RAM_WR1, RAM_WR2, RAM_WR3,
		IO_RD1, IO_RD2
	} ctrl_state_e;

	// Processor request, held until served
	typedef struct packed {
		logic              valid;
		logic              rd;
		logic              wr;
		logic [tag_w-1:0]  tag;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic              en_n;
		logic              oe_n;
		logic              we_n;
		logic [addr_w-1:0] addr;
	} sram_pins_t;

	typedef struct packed {
		logic rdn;
		logic wrn;
	} uart_pins_t;

	typedef struct packed {
		logic data_ready;
		logic tbre;
		logic tsre;
	} uart_flags_t;

endpackage

// File: source/mem_uart_top.sv
`timescale 1ns/1ns

module mem_uart_top (
	input  logic                                clk,
	input  logic                                rst,
	input  mem_uart_pkg::mem_req_t              req,
	output logic                                done,
	output logic [mem_uart_pkg::tag_w-1:0]      done_tag,
	output logic [mem_uart_pkg::data_w-1:0]     result,
	output mem_uart_pkg::sram_pins_t            sram,
	output mem_uart_pkg::uart_pins_t            uart,
	input  mem_uart_pkg::uart_flags_t           flags,
	output logic [mem_uart_pkg::data_w-1:0]     bus_out,
	output logic                                bus_oe,
	input  logic [mem_uart_pkg::data_w-1:0]     bus_in
);

	// Queue handshake
	logic                            push;
	logic [mem_uart_pkg::data_w-1:0] push_data;
	logic                            pop;
	logic [mem_uart_pkg::data_w-1:0] front_data;
	logic                            empty;
	logic                            full;

	// Status block handshake
	mem_uart_pkg::uart_flags_t       flags_sync;
	logic                            drop;
	logic                            status_rd;
	logic [mem_uart_pkg::data_w-1:0] status_word;

	mem_bus_ctrl i_mem_bus_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.done        (done),
		.done_tag    (done_tag),
		.result      (result),
		.sram        (sram),
		.uart        (uart),
		.flags_sync  (flags_sync),
		.bus_out     (bus_out),
		.bus_oe      (bus_oe),
		.bus_in      (bus_in),
		.push        (push),
		.push_data   (push_data),
		.pop         (pop),
		.front_data  (front_data),
		.empty       (empty),
		.full        (full),
		.drop        (drop),
		.status_rd   (status_rd),
		.status_word (status_word)
	);

	rx_queue i_rx_queue (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.front_data (front_data),
		.empty      (empty),
		.full       (full)
	);

	io_status_regs i_io_status_regs (
		.clk         (clk),
		.rst         (rst),
		.flags       (flags),
		.flags_sync  (flags_sync),
		.empty       (empty),
		.drop        (drop),
		.status_rd   (status_rd),
		.status_word (status_word)
	);

endmodule

// File: source/rx_queue.sv
`timescale 1ns/1ns

module rx_queue (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            push,
	input  logic [mem_uart_pkg::data_w-1:0] push_data,
	input  logic                            pop,
	output logic [mem_uart_pkg::data_w-1:0] front_data,
	output logic                            empty,
	output logic                            full
);

	logic [mem_uart_pkg::data_w-1:0] mem [mem_uart_pkg::queue_depth];
	logic [mem_uart_pkg::ptr_w-1:0]  front;
	logic [mem_uart_pkg::ptr_w-1:0]  tail;
	logic [mem_uart_pkg::ptr_w:0]    count;
	logic                            do_push;
	logic                            do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	// Depth is a power of two, top count bit means full
	assign full  = count[mem_uart_pkg::ptr_w];

	// Oldest entry, no register stage
	assign front_data = mem[front];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail] <= push_data;
	end

	// Pointers wrap at the array size
	always_ff @(posedge clk) begin
		if (!rst) begin
			front <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail <= tail + 1'b1;
			if (do_pop)
				front <= front + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verif/mem_uart_checker.sv
`timescale 1ns/1ns

module mem_uart_checker (
	input logic                      clk,
	input logic                      rst,
	input mem_uart_pkg::ctrl_state_e state,
	input mem_uart_pkg::sram_pins_t  sram,
	input mem_uart_pkg::uart_pins_t  uart,
	input logic                      bus_oe,
	input logic                      done
);

	////////////////////////////////////////////////////////////
	// Pin strobe exclusion
	////////////////////////////////////////////////////////////
	oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(!sram.oe_n && !sram.we_n))
		else $error("SRAM oe_n and we_n low together");

	// UART chip must stay quiet during an SRAM cycle
	uart_quiet_on_sram: assert property (@(posedge clk) disable iff (!rst)
		!sram.en_n |-> (uart.rdn && uart.wrn))
		else $error("UART strobe low while SRAM enabled");

	bus_no_contention: assert property (@(posedge clk) disable iff (!rst)
		!(bus_oe && !sram.oe_n))
		else $error("Data bus driven while SRAM output enabled");

	////////////////////////////////////////////////////////////
	// SRAM latency
	////////////////////////////////////////////////////////////
	sram_read_latency: assert property (@(posedge clk) disable iff (!rst)
		(state == mem_uart_pkg::RAM_RD1) |-> ##3 $rose(done))
		else $error("SRAM read not done after 3 cycles");

	sram_write_latency: assert property (@(posedge clk) disable iff (!rst)
		(state == mem_uart_pkg::RAM_WR1) |-> ##3 $rose(done))
		else $error("SRAM write not done after 3 cycles");

	// Write pulse is exactly one cycle wide
	we_pulse_width: assert property (@(posedge clk) disable iff (!rst)
		$fell(sram.we_n) |=> sram.we_n)
		else $error("SRAM we_n low for more than one cycle");

endmodule

bind mem_bus_ctrl mem_uart_checker i_mem_uart_checker (
	.clk    (clk),
	.rst    (rst),
	.state  (state),
	.sram   (sram),
	.uart   (uart),
	.bus_oe (bus_oe),
	.done   (done)
);

// File: verif/tb_mem_uart.sv
`timescale 1ns/1ns

module tb_mem_uart;

	localparam int clk_period = 20;
	// About 70 requests plus 22 received bytes, well under 2000 cycles
	localparam int watchdog_ns = 200_000;

	logic                              clk;
	logic                              rst;
	mem_uart_pkg::mem_req_t            req;
	logic                              done;
	logic [mem_uart_pkg::tag_w-1:0]    done_tag;
	logic [mem_uart_pkg::data_w-1:0]   result;
	mem_uart_pkg::sram_pins_t          sram;
	mem_uart_pkg::uart_pins_t          uart;
	mem_uart_pkg::uart_flags_t         flags;
	logic [mem_uart_pkg::data_w-1:0]   bus_out;
	logic                              bus_oe;
	logic [mem_uart_pkg::data_w-1:0]   bus_in;

	// Models and expected values
	logic [15:0] sram_mem [256];
	logic [15:0] shadow [256];
	logic [7:0]  rx_list [$];
	logic [7:0]  rx_sent [$];
	logic [7:0]  rx_cur;
	logic        rx_ready;
	int          rx_taken;
	logic        tbre_m;
	logic        tsre_m;
	logic        tsre_back;
	logic        tx_hold;
	logic [15:0] tx_log;
	int          tx_count;
	logic [3:0]  tag;
	int          seed;

	mem_uart_top i_mem_uart_top (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.done     (done),
		.done_tag (done_tag),
		.result   (result),
		.sram     (sram),
		.uart     (uart),
		.flags    (flags),
		.bus_out  (bus_out),
		.bus_oe   (bus_oe),
		.bus_in   (bus_in)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish in time");
		$display("TESTS FAILED");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// Bus resolution and chip models
	////////////////////////////////////////////////////////////
	assign flags = '{data_ready: rx_ready, tbre: tbre_m && !tx_hold, tsre: tsre_m};

	// UART chip drives only the low byte, high byte is junk
	always_comb begin
		if (!sram.oe_n)
			bus_in = sram_mem[sram.addr[7:0]];
		else if (!uart.rdn)
			bus_in = {8'hA5, rx_cur};
		else
			bus_in = 16'h0000;
	end

	always @(posedge sram.we_n) begin
		if (rst)
			sram_mem[sram.addr[7:0]] = bus_out;
	end

	// Controller must own the bus while the SRAM is written
	always @(negedge sram.we_n) begin
		check_true(bus_oe, "bus_oe was low when we_n fell");
	end

	initial begin
		rx_ready = 1'b0;
		rx_cur   = 8'h00;
		rx_taken = 0;
		@(posedge rst);
		forever begin
			@(negedge clk);
			if (rx_list.size() > 0) begin
				rx_cur   = rx_list.pop_front();
				rx_ready = 1'b1;
				@(negedge uart.rdn);
				@(negedge clk);
				rx_ready = 1'b0;
				@(posedge uart.rdn);
				rx_taken++;
				repeat (2) @(negedge clk);
			end
		end
	end

	initial begin
		tbre_m    = 1'b1;
		tsre_m    = 1'b1;
		tsre_back = 1'b1;
		tx_count  = 0;
		tx_log    = 16'h0000;
		forever begin
			@(negedge uart.wrn);
			tx_log = bus_out;
			tx_count++;
			check_true(bus_oe, "bus_oe was low when wrn fell");
			@(negedge clk);
			tbre_m    = 1'b0;
			tsre_m    = 1'b0;
			tsre_back = 1'b0;
			repeat (4) @(negedge clk);
			tbre_m = 1'b1;
			repeat (3) @(negedge clk);
			tsre_m    = 1'b1;
			tsre_back = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and request helpers
	////////////////////////////////////////////////////////////
	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("Check failed: %s", what);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic access(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		tag = tag + 1'b1;
		req = '{valid: 1'b1, rd: !wr, wr: wr, tag: tag, addr: addr, wdata: wdata};
		do @(negedge clk); while (!(done && done_tag == tag));
		rdata     = result;
		req.valid = 1'b0;
	endtask

	task automatic send_bytes(input int n);
		int target;
		logic [7:0] b;
		target = rx_taken + n;
		for (int i = 0; i < n; i++) begin
			b = 8'($random(seed));
			rx_list.push_back(b);
			rx_sent.push_back(b);
		end
		while (rx_taken < target)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	initial begin
		logic [15:0] addrs [20];
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] r;
		int          prev;

		seed    = 82432;
		rst     = 1'b0;
		req     = '0;
		tag     = 4'h0;
		tx_hold = 1'b0;
		for (int i = 0; i < 256; i++) begin
			sram_mem[i] = {i[7:0], ~i[7:0]};
			shadow[i]   = {i[7:0], ~i[7:0]};
		end
		repeat (10) @(negedge clk);
		rst = 1'b1;
		repeat (3) @(negedge clk);

		// Idle pin levels out of reset
		check_eq("sram.en_n", 16'(sram.en_n), 16'h0001);
		check_eq("sram.oe_n", 16'(sram.oe_n), 16'h0001);
		check_eq("sram.we_n", 16'(sram.we_n), 16'h0001);
		check_eq("uart.rdn", 16'(uart.rdn), 16'h0001);
		check_eq("uart.wrn", 16'(uart.wrn), 16'h0001);
		check_eq("bus_oe", 16'(bus_oe), 16'h0000);
		check_eq("done", 16'(done), 16'h0000);

		// SRAM write then read back
		for (int i = 0; i < 20; i++) begin
			a = 16'($random(seed));
			if (a[15:8] == 8'hBF)
				a[15:8] = 8'h3C;
			d = 16'($random(seed));
			addrs[i] = a;
			shadow[a[7:0]] = d;
			access(1'b1, a, d, r);
		end
		for (int i = 0; i < 20; i++) begin
			access(1'b0, addrs[i], 16'h0000, r);
			check_eq("result", r, shadow[addrs[i][7:0]]);
		end

		// Receive five bytes and read them back
		send_bytes(5);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0003);
		for (int i = 0; i < 5; i++) begin
			access(1'b0, mem_uart_pkg::uart_data_addr, 16'h0000, r);
			check_eq("result", r, {8'h00, rx_sent.pop_front()});
		end
		access(1'b0, mem_uart_pkg::uart_data_addr, 16'h0000, r);
		check_eq("result", r, 16'h0000);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0001);

		// Transmit one byte
		d    = 16'($random(seed));
		prev = tx_count;
		access(1'b1, mem_uart_pkg::uart_data_addr, d, r);
		check_true(tx_count == prev + 1, "wrn did not pulse exactly once for the UART write");
		check_eq("bus_out", tx_log, {8'h00, d[7:0]});
		check_true(tsre_back, "done rose before the UART model restored tsre");

		// Transmitter busy shows in the status word
		tx_hold = 1'b1;
		repeat (4) @(negedge clk);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0000);
		tx_hold = 1'b0;
		repeat (4) @(negedge clk);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0001);

		// Overflow, seventeenth byte is dropped
		send_bytes(17);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0007);
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0003);
		for (int i = 0; i < 16; i++) begin
			access(1'b0, mem_uart_pkg::uart_data_addr, 16'h0000, r);
			check_eq("result", r, {8'h00, rx_sent.pop_front()});
		end
		void'(rx_sent.pop_front());
		access(1'b0, mem_uart_pkg::uart_status_addr, 16'h0000, r);
		check_eq("status", r, 16'h0001);

		$display("TESTS PASSED");
		$finish;
	end

endmodule
